// File: turfio_regs.f
+incdir+.
turfio_pkg.sv
turfio_intercon.sv
tio_id_ctrl.sv
gen_shift.sv
turfio_regs_top.sv
turfio_regs_checker.sv
turfio_regs_asserts.sv
tb_turfio_regs.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_turfio_regs
FILELIST  ?= turfio_regs.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_turfio_regs.sv
`timescale 1ns/100ps
`default_nettype none
`include "turfio_macros.svh"

module tb_turfio_regs;
    import turfio_pkg::*;

    localparam int RSP_TIMEOUT = 200;
    localparam int POLL_MAX    = 100;
    localparam logic [21:0] ID_BASE = 22'h000000;
    localparam logic [21:0] SH_BASE = 22'h001000;

    logic       wb_clk_i;
    logic       reset_i;
    wb_req_t    dbg_req;
    wb_req_t    ctl_req;
    wb_rsp_t    dbg_rsp;
    wb_rsp_t    ctl_rsp;
    logic       en_3v3;
    logic       jtag_en;
    logic       lmk_oe;
    logic       sclk;
    logic       sdo;
    logic       sdi;
    logic [2:0] tgt_en;
    logic       inv;
    logic       timed_out;

    // Serial loopback, optionally inverted
    assign sdi = sdo ^ inv;

    initial begin
        wb_clk_i = 1'b0;
        forever #5 wb_clk_i = ~wb_clk_i;
    end

    turfio_regs_top i_turfio_regs_top (
        .wb_clk_i (wb_clk_i), .reset_i (reset_i),
        .dbg_req_i (dbg_req), .dbg_rsp_o (dbg_rsp),
        .ctl_req_i (ctl_req), .ctl_rsp_o (ctl_rsp),
        .en_3v3_o (en_3v3), .jtag_en_o (jtag_en), .lmk_oe_o (lmk_oe),
        .sclk_o (sclk), .sdo_o (sdo), .sdi_i (sdi), .tgt_en_o (tgt_en)
    );

    turfio_regs_checker i_checker (
        .wb_clk_i (wb_clk_i), .reset_i (reset_i),
        .dbg_req_i (dbg_req), .ctl_req_i (ctl_req),
        .dbg_rsp_i (dbg_rsp), .ctl_rsp_i (ctl_rsp),
        .en_3v3_i (en_3v3), .jtag_en_i (jtag_en), .lmk_oe_i (lmk_oe),
        .sclk_i (sclk), .sdo_i (sdo), .tgt_en_i (tgt_en), .inv_i (inv)
    );

    task automatic finish_run();
        i_checker.report_counts();
        if (i_checker.errors == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus master, port 0 debug, port 1 control
    ////////////////////////////////////////////////////////////////////////////

    task automatic xfer(input bit port, input logic we, input logic [21:0] adr,
                        input logic [31:0] dat, output logic [31:0] rdat);
        int      n;
        wb_rsp_t rsp;
        n   = 0;
        rsp = '0;
        @(posedge wb_clk_i);
        #1;
        if (port) ctl_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        else      dbg_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        while (!(rsp.ack || rsp.err) && n < RSP_TIMEOUT) begin
            @(posedge wb_clk_i);
            #1;
            rsp = port ? ctl_rsp : dbg_rsp;
            n++;
        end
        // Request stays up until the ack cycle has closed
        @(posedge wb_clk_i);
        #1;
        if (port) ctl_req = '0;
        else      dbg_req = '0;
        rdat = rsp.dat;
        if (n >= RSP_TIMEOUT) begin
            $display("timeout: no response on port %0d for address %h", port, adr);
            timed_out = 1'b1;
            finish_run();
        end
    endtask

    // One random access, no shift starts
    task automatic rand_op(input bit port);
        logic [31:0] r;
        logic [21:0] adr;
        logic [31:0] d;
        d = $urandom;
        case ($urandom % 6)
            0: adr = ID_BASE | 22'(($urandom % 4) * 4);
            1: adr = SH_BASE | 22'(12'h004 + (($urandom % 3) * 4));
            2: adr = {8'($urandom), 2'd2 + 2'($urandom % 2), 12'($urandom) & 12'hFFC};
            default: adr = ID_BASE | 22'h008 | (22'($urandom % 2) << 2);
        endcase
        xfer(port, 1'($urandom), adr, d, r);
    endtask

    task automatic burst(input bit port, input int n);
        for (int i = 0; i < n; i++) begin
            repeat ($urandom % 3) @(posedge wb_clk_i);
            rand_op(port);
        end
    endtask

    task automatic run_shift(input bit busy_poke);
        logic [31:0] r;
        int          n;
        xfer(0, 1'b1, SH_BASE | 22'h004, $urandom, r);
        xfer(1, 1'b1, SH_BASE, {22'd0, 2'($urandom), 3'd0, 5'($urandom)}, r);
        // Control write while busy must be ignored
        if (busy_poke)
            xfer(0, 1'b1, SH_BASE, 32'h0000_0103, r);
        n = 0;
        r = 32'd1;
        while (r[0] && n < POLL_MAX) begin
            xfer(0, 1'b0, SH_BASE | 22'h00C, '0, r);
            n++;
        end
        if (r[0]) begin
            $display("timeout: shift engine still busy after %0d status polls", n);
            timed_out = 1'b1;
            finish_run();
        end
        xfer(1, 1'b0, SH_BASE | 22'h008, '0, r);
        xfer(0, 1'b0, SH_BASE, '0, r);
    endtask

    initial begin
        logic [31:0] r;
        timed_out = 1'b0;
        reset_i   = 1'b1;
        dbg_req   = '0;
        ctl_req   = '0;
        void'($urandom(32'hac60_516f));
        inv = 1'($urandom);
        repeat (16) @(posedge wb_clk_i);
        #1;
        reset_i = 1'b0;

        // Reset values of every register
        for (int i = 0; i < 4; i++) begin
            xfer(0, 1'b0, ID_BASE | 22'(i * 4), '0, r);
            xfer(0, 1'b0, SH_BASE | 22'(i * 4), '0, r);
        end
        i_checker.end_test("reset_values");

        for (int p = 0; p < 2; p++) begin
            xfer(1'(p), 1'b0, ID_BASE | 22'h000, '0, r);
            xfer(1'(p), 1'b0, ID_BASE | 22'h004, '0, r);
        end
        i_checker.end_test("ident_version");

        for (int i = 0; i < 20; i++) begin
            xfer(1'(i), 1'b1, ID_BASE | 22'h008, $urandom, r);
            xfer(1'(i + 1), 1'b0, ID_BASE | 22'h008, '0, r);
            xfer(1'(i), 1'b1, ID_BASE | 22'h00C, $urandom, r);
            xfer(1'(i + 1), 1'b0, ID_BASE | 22'h00C, '0, r);
        end
        i_checker.end_test("scratch_control");

        fork
            burst(0, 40);
            burst(1, 40);
        join
        i_checker.end_test("contested");

        for (int i = 0; i < 20; i++)
            xfer(1'(i), 1'($urandom),
                 {8'($urandom), 2'd2 + 2'($urandom % 2), 12'($urandom) & 12'hFFC},
                 $urandom, r);
        xfer(0, 1'b0, ID_BASE | 22'h008, '0, r);
        xfer(1, 1'b0, ID_BASE | 22'h00C, '0, r);
        i_checker.end_test("unmapped");

        for (int i = 0; i < 8; i++)
            run_shift(i == 3);
        i_checker.end_test("shift");

        finish_run();
    end

endmodule

`default_nettype wire

// File: turfio_regs_asserts.sv
`timescale 1ns/100ps
`default_nettype none
`include "turfio_macros.svh"

module turfio_regs_asserts (
    input wire                          wb_clk_i,
    input wire                          reset_i,
    input wire turfio_pkg::wb_req_t     dbg_req_i,
    input wire turfio_pkg::wb_req_t     ctl_req_i,
    input wire turfio_pkg::wb_rsp_t     dbg_rsp_o,
    input wire turfio_pkg::wb_rsp_t     ctl_rsp_o,
    input wire turfio_pkg::wbs_req_t    id_req_o,
    input wire turfio_pkg::wbs_req_t    sh_req_o,
    input wire turfio_pkg::arb_state_t  state_q
);
    import turfio_pkg::*;

    // Select field of the master request being served
    logic [1:0] srv_sel;

    assign srv_sel = (state_q == ARB_CTL) ? ctl_req_i.adr[`TIO_SEL_LSB +: 2]
                                          : dbg_req_i.adr[`TIO_SEL_LSB +: 2];

    // One slave strobe at most, and the one the address selects
    a_one_slave: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        (id_req_o.stb || sh_req_o.stb)
        |-> (!(id_req_o.stb && sh_req_o.stb) && srv_sel == {1'b0, sh_req_o.stb}))
        else $error("slave strobe does not match the granted address");

    // Responses only to a master with a request outstanding
    a_dbg_gnt: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        (dbg_rsp_o.ack || dbg_rsp_o.err) |-> (dbg_req_i.cyc && dbg_req_i.stb))
        else $error("response to debug master without a pending request");
    a_ctl_gnt: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        (ctl_rsp_o.ack || ctl_rsp_o.err) |-> (ctl_req_i.cyc && ctl_req_i.stb))
        else $error("response to control master without a pending request");

    // Request held until its response
    a_dbg_hold: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        (dbg_req_i.stb && !(dbg_rsp_o.ack || dbg_rsp_o.err))
        |=> ($stable(dbg_req_i) || dbg_rsp_o.ack || dbg_rsp_o.err))
        else $error("debug request changed before response");
    a_ctl_hold: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        (ctl_req_i.stb && !(ctl_rsp_o.ack || ctl_rsp_o.err))
        |=> ($stable(ctl_req_i) || ctl_rsp_o.ack || ctl_rsp_o.err))
        else $error("control request changed before response");

endmodule

bind turfio_intercon turfio_regs_asserts i_asserts (
    .wb_clk_i  (wb_clk_i),
    .reset_i   (reset_i),
    .dbg_req_i (dbg_req_i),
    .ctl_req_i (ctl_req_i),
    .dbg_rsp_o (dbg_rsp_o),
    .ctl_rsp_o (ctl_rsp_o),
    .id_req_o  (id_req_o),
    .sh_req_o  (sh_req_o),
    .state_q   (state_q)
);

`default_nettype wire

// File: turfio_regs_checker.sv
`timescale 1ns/100ps
`default_nettype none
`include "turfio_macros.svh"

module turfio_regs_checker (
    input wire                      wb_clk_i,
    input wire                      reset_i,
    input wire turfio_pkg::wb_req_t dbg_req_i,
    input wire turfio_pkg::wb_req_t ctl_req_i,
    input wire turfio_pkg::wb_rsp_t dbg_rsp_i,
    input wire turfio_pkg::wb_rsp_t ctl_rsp_i,
    input wire                      en_3v3_i,
    input wire                      jtag_en_i,
    input wire                      lmk_oe_i,
    input wire                      sclk_i,
    input wire                      sdo_i,
    input wire [2:0]                tgt_en_i,
    // Loopback inversion chosen by the testbench
    input wire                      inv_i
);
    import turfio_pkg::*;

    int          checks;
    int          errors;
    int          tests;
    int          test_errors;
    // Register model
    logic [31:0] m_scratch;
    logic [2:0]  m_ctrl;
    logic [31:0] m_tx;
    logic [31:0] m_rx;
    logic [4:0]  m_cnt;
    logic [1:0]  m_tgt;
    // Expected shift, latched when a start is acked
    int          sh_n;
    logic [31:0] sh_bits;
    // Pin monitor
    logic        busy_prev;
    logic        sclk_prev;
    logic        rst_prev;
    int          edges;
    logic [31:0] bits_seen;

    function automatic logic [31:0] low_mask(input int n);
        return (n >= 32) ? 32'hFFFF_FFFF : ((32'h1 << n) - 32'h1);
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("error t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic complain(input string what);
        errors++;
        test_errors++;
        $display("t=%0t %s", $time, what);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Expected read data from the register map rules
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] model_read(input logic [1:0] sel, input logic [11:0] off);
        if (sel == 2'd0) begin
            case (off)
                12'h000: return 32'h5446_494F;
                12'h004: return {16'h0000, 4'd0, 4'd1, 8'd2};
                12'h008: return m_scratch;
                12'h00C: return {29'd0, m_ctrl};
                default: return 32'd0;
            endcase
        end
        case (off)
            12'h000: return {22'd0, m_tgt, 3'd0, m_cnt};
            12'h004: return m_tx;
            12'h008: return m_rx;
            12'h00C: return {31'd0, busy_prev};
            default: return 32'd0;
        endcase
    endfunction

    task automatic model_write(input logic [1:0] sel, input logic [11:0] off,
                               input logic [31:0] dat);
        if (sel == 2'd0 && off == 12'h008)
            m_scratch = dat;
        if (sel == 2'd0 && off == 12'h00C)
            m_ctrl = dat[2:0];
        if (sel == 2'd1 && off == 12'h004)
            m_tx = dat;
        // Start only when idle, otherwise dropped
        if (sel == 2'd1 && off == 12'h000 && !busy_prev) begin
            m_cnt   = dat[4:0];
            m_tgt   = (dat[9:8] == 2'd3) ? 2'd2 : dat[9:8];
            sh_n    = (dat[4:0] == 5'd0) ? 32 : int'(dat[4:0]);
            sh_bits = m_tx & low_mask(sh_n);
        end
    endtask

    task automatic check_rsp(input string port, input wb_req_t req, input wb_rsp_t rsp);
        logic [1:0]  sel;
        logic [11:0] off;
        sel = req.adr[`TIO_SEL_LSB +: 2];
        off = req.adr[11:0];
        if (!(req.cyc && req.stb))
            complain({"response on ", port, " port with no request pending"});
        if (sel[1]) begin
            // Unmapped window
            compare({port, "_rsp.ack"}, rsp.ack, 1'b0);
            compare({port, "_rsp.err"}, rsp.err, 1'b1);
        end else begin
            compare({port, "_rsp.ack"}, rsp.ack, 1'b1);
            compare({port, "_rsp.err"}, rsp.err, 1'b0);
            if (req.we)
                model_write(sel, off, req.dat);
            else if (!(sel == 2'd1 && off == 12'h008 && busy_prev))
                compare({port, "_rsp.dat"}, rsp.dat, model_read(sel, off));
        end
        compare("en_3v3_o", en_3v3_i, m_ctrl[0]);
        compare("jtag_en_o", jtag_en_i, m_ctrl[1]);
        compare("lmk_oe_o", lmk_oe_i, m_ctrl[2]);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Monitor, sampled on the falling edge away from the drive point
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge wb_clk_i) begin
        if (reset_i) begin
            m_scratch = '0;
            m_ctrl    = '0;
            m_tx      = '0;
            m_rx      = '0;
            m_cnt     = '0;
            m_tgt     = '0;
            busy_prev = 1'b0;
            sclk_prev = 1'b0;
            edges     = 0;
            bits_seen = '0;
        end else begin
            if (rst_prev) begin
                // Out of reset, every pin low
                compare("pins", {en_3v3_i, jtag_en_i, lmk_oe_i, sclk_i, sdo_i, tgt_en_i}, '0);
                compare("rsp", {dbg_rsp_i.ack, dbg_rsp_i.err, ctl_rsp_i.ack, ctl_rsp_i.err}, '0);
            end
            if (dbg_rsp_i.ack || dbg_rsp_i.err)
                check_rsp("dbg", dbg_req_i, dbg_rsp_i);
            if (ctl_rsp_i.ack || ctl_rsp_i.err)
                check_rsp("ctl", ctl_req_i, ctl_rsp_i);

            // Shift start seen on the enables
            if (!busy_prev && tgt_en_i != 3'b000) begin
                edges     = 0;
                bits_seen = '0;
            end
            if (tgt_en_i != 3'b000)
                compare("tgt_en_o", tgt_en_i, 3'b001 << m_tgt);
            if (sclk_i && !sclk_prev) begin
                edges++;
                bits_seen = {bits_seen[30:0], sdo_i};
            end
            // Shift end, compare whole word
            if (busy_prev && tgt_en_i == 3'b000) begin
                compare("sclk_o rising edges", edges, sh_n);
                compare("sdo_o bits", bits_seen, sh_bits);
                m_rx = (sh_bits ^ ({32{inv_i}} & low_mask(sh_n)));
            end
            busy_prev = (tgt_en_i != 3'b000);
            sclk_prev = sclk_i;
        end
        rst_prev = reset_i;
    end

    task automatic end_test(input string name);
        tests++;
        $display("test %-16s %s  errors=%0d", name, (test_errors == 0) ? "ok" : "FAIL",
                 test_errors);
        test_errors = 0;
    endtask

    task automatic report_counts();
        $display("tests=%0d checks=%0d errors=%0d", tests, checks, errors);
    endtask

endmodule

`default_nettype wire

// File: turfio_regs_top.sv
`timescale 1ns/100ps
`default_nettype none

module turfio_regs_top (
    input  wire                      wb_clk_i,
    input  wire                      reset_i,
    // Debug master, serial bridge on the board
    input  wire turfio_pkg::wb_req_t dbg_req_i,
    output wire turfio_pkg::wb_rsp_t dbg_rsp_o,
    // Control master
    input  wire turfio_pkg::wb_req_t ctl_req_i,
    output wire turfio_pkg::wb_rsp_t ctl_rsp_o,
    // Board enables
    output wire                      en_3v3_o,
    output wire                      jtag_en_o,
    output wire                      lmk_oe_o,
    // Shared serial lines
    output wire                      sclk_o,
    output wire                      sdo_o,
    input  wire                      sdi_i,
    // JTAG, LMK, SPI enables
    output wire [2:0]                tgt_en_o
);
    import turfio_pkg::*;

    wire wbs_req_t id_req;
    wire wbs_req_t sh_req;
    wire wb_rsp_t  id_rsp;
    wire wb_rsp_t  sh_rsp;

    // Arbiter and decoder
    turfio_intercon i_intercon (
        .wb_clk_i  (wb_clk_i),
        .reset_i   (reset_i),
        .dbg_req_i (dbg_req_i),
        .ctl_req_i (ctl_req_i),
        .dbg_rsp_o (dbg_rsp_o),
        .ctl_rsp_o (ctl_rsp_o),
        .id_req_o  (id_req),
        .sh_req_o  (sh_req),
        .id_rsp_i  (id_rsp),
        .sh_rsp_i  (sh_rsp)
    );

    // Window 0 at 0x000000
    tio_id_ctrl i_id_ctrl (
        .wb_clk_i  (wb_clk_i),
        .reset_i   (reset_i),
        .req_i     (id_req),
        .rsp_o     (id_rsp),
        .en_3v3_o  (en_3v3_o),
        .jtag_en_o (jtag_en_o),
        .lmk_oe_o  (lmk_oe_o)
    );

    // Window 1 at 0x001000
    gen_shift i_gen_shift (
        .wb_clk_i (wb_clk_i),
        .reset_i  (reset_i),
        .req_i    (sh_req),
        .rsp_o    (sh_rsp),
        .sclk_o   (sclk_o),
        .sdo_o    (sdo_o),
        .sdi_i    (sdi_i),
        .tgt_en_o (tgt_en_o)
    );

endmodule

`default_nettype wire

// File: gen_shift.sv
`timescale 1ns/100ps
`default_nettype none
`include "turfio_macros.svh"

module gen_shift (
    input  wire                      wb_clk_i,
    input  wire                      reset_i,
    input  wire turfio_pkg::wbs_req_t req_i,
    output turfio_pkg::wb_rsp_t      rsp_o,
    output logic                     sclk_o,
    output logic                     sdo_o,
    input  wire                      sdi_i,
    output logic [2:0]               tgt_en_o
);
    import turfio_pkg::*;

    localparam int         CW       = `TIO_SH_CNT_W;
    localparam int         TGT_LSB  = `TIO_SH_TGT_LSB;
    // Half-period counter reload
    localparam logic [7:0] DIV_LOAD = 8'(`TIO_SHIFT_DIV - 1);

    shift_state_t          state_q;
    shift_target_t         tgt_q;
    shift_target_t         wr_tgt;
    // Count field as written, 0 means 32
    logic [CW-1:0]         cnt_q;
    logic [`TIO_DAT_W-1:0] tx_q;
    logic [`TIO_DAT_W-1:0] rx_q;
    logic [`TIO_DAT_W-1:0] sh_tx_q;
    logic [5:0]            bits_q;
    logic [5:0]            wr_bits;
    logic [7:0]            div_q;
    logic                  sclk_q;
    logic [2:0]            en_q;
    logic                  ack_q;
    logic [`TIO_DAT_W-1:0] dat_q;
    logic [`TIO_DAT_W-1:0] rd_dat;
    logic                  access;
    logic                  wr;
    logic                  busy;
    logic                  start;
    logic                  half_done;

    assign access    = req_i.cyc & req_i.stb & ~ack_q;
    assign wr        = access & req_i.we;
    assign busy      = (state_q != SH_IDLE);
    // Control write while busy gets acked but dropped
    assign start     = wr & (req_i.adr == `REG_SH_CTRL) & ~busy;
    assign half_done = (div_q == '0);
    assign wr_bits   = (req_i.dat[CW-1:0] == '0) ? 6'd32 : {1'b0, req_i.dat[CW-1:0]};

    // Illegal code 3 folds onto SPI
    always_comb begin
        case (req_i.dat[TGT_LSB +: 2])
            2'd0:    wr_tgt = TGT_JTAG;
            2'd1:    wr_tgt = TGT_LMK;
            default: wr_tgt = TGT_SPI;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (req_i.adr)
            `REG_SH_CTRL: rd_dat = {22'd0, tgt_q, 3'd0, cnt_q};
            `REG_SH_TX:   rd_dat = tx_q;
            `REG_SH_RX:   rd_dat = rx_q;
            `REG_SH_STAT: rd_dat = {31'd0, busy};
            default:      rd_dat = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////
    // Shift FSM
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state_q <= SH_IDLE;
            tgt_q   <= TGT_JTAG;
            cnt_q   <= '0;
            tx_q    <= '0;
            rx_q    <= '0;
            bits_q  <= '0;
            div_q   <= '0;
            sclk_q  <= 1'b0;
            en_q    <= '0;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= access;
            // TX may be reloaded mid-shift, working copy is separate
            if (wr && req_i.adr == `REG_SH_TX) begin
                tx_q <= req_i.dat;
            end
            case (state_q)
                SH_IDLE: begin
                    if (start) begin
                        cnt_q   <= req_i.dat[CW-1:0];
                        tgt_q   <= wr_tgt;
                        bits_q  <= wr_bits;
                        rx_q    <= '0;
                        div_q   <= DIV_LOAD;
                        en_q    <= 3'b001 << wr_tgt;
                        state_q <= SH_LOW;
                    end
                end
                SH_LOW: begin
                    if (half_done) begin
                        // Sample on the rising serial clock
                        sclk_q  <= 1'b1;
                        rx_q    <= {rx_q[`TIO_DAT_W-2:0], sdi_i};
                        div_q   <= DIV_LOAD;
                        state_q <= SH_HIGH;
                    end else begin
                        div_q <= div_q - 8'd1;
                    end
                end
                SH_HIGH: begin
                    if (half_done) begin
                        sclk_q  <= 1'b0;
                        div_q   <= DIV_LOAD;
                        bits_q  <= bits_q - 6'd1;
                        state_q <= (bits_q == 6'd1) ? SH_DONE : SH_LOW;
                    end else begin
                        div_q <= div_q - 8'd1;
                    end
                end
                default: begin
                    // Drop enable, busy clears next
                    en_q    <= '0;
                    state_q <= SH_IDLE;
                end
            endcase
        end
    end

    // Working shift register and read data
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            dat_q <= rd_dat;
        end
        if (start) begin
            // MSB-align the active bits
            sh_tx_q <= tx_q << (6'd32 - wr_bits);
        end else if (state_q == SH_HIGH && half_done) begin
            // Next bit presented at start of low phase
            sh_tx_q <= {sh_tx_q[`TIO_DAT_W-2:0], 1'b0};
        end
    end

    assign rsp_o    = '{ack: ack_q, err: 1'b0, dat: dat_q};
    assign sclk_o   = sclk_q;
    assign sdo_o    = ((state_q == SH_LOW) || (state_q == SH_HIGH)) & sh_tx_q[`TIO_DAT_W-1];
    assign tgt_en_o = en_q;

endmodule

`default_nettype wire

// File: tio_id_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "turfio_macros.svh"

module tio_id_ctrl (
    input  wire                      wb_clk_i,
    input  wire                      reset_i,
    input  wire turfio_pkg::wbs_req_t req_i,
    output turfio_pkg::wb_rsp_t      rsp_o,
    output logic                     en_3v3_o,
    output logic                     jtag_en_o,
    output logic                     lmk_oe_o
);

    logic                  ack_q;
    logic [`TIO_DAT_W-1:0] dat_q;
    logic [`TIO_DAT_W-1:0] scratch_q;
    // Board enables: [0] 3V3, [1] JTAG, [2] LMK outputs
    logic [2:0]            ctrl_q;
    logic                  access;
    logic                  wr;
    logic [`TIO_DAT_W-1:0] rd_dat;

    // First cycle of a strobe only
    assign access = req_i.cyc & req_i.stb & ~ack_q;
    assign wr     = access & req_i.we;

    ////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (req_i.adr)
            `REG_IDENT:   rd_dat = `TIO_IDENT;
            `REG_VERSION: rd_dat = `TIO_VERSION;
            `REG_SCRATCH: rd_dat = scratch_q;
            `REG_CONTROL: rd_dat = {29'd0, ctrl_q};
            // Holes read as zero
            default:      rd_dat = '0;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_q     <= 1'b0;
            scratch_q <= '0;
            ctrl_q    <= '0;
        end else begin
            // Ack lands exactly one cycle after strobe
            ack_q <= access;
            if (wr && req_i.adr == `REG_SCRATCH) begin
                scratch_q <= req_i.dat;
            end
            if (wr && req_i.adr == `REG_CONTROL) begin
                ctrl_q <= req_i.dat[2:0];
            end
        end
    end

    // Registered read data
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            dat_q <= rd_dat;
        end
    end

    // Never errors
    assign rsp_o = '{ack: ack_q, err: 1'b0, dat: dat_q};

    assign en_3v3_o  = ctrl_q[0];
    assign jtag_en_o = ctrl_q[1];
    assign lmk_oe_o  = ctrl_q[2];

endmodule

`default_nettype wire

// File: turfio_intercon.sv
`timescale 1ns/100ps
`default_nettype none
`include "turfio_macros.svh"

module turfio_intercon (
    input  wire                     wb_clk_i,
    input  wire                     reset_i,
    input  wire turfio_pkg::wb_req_t dbg_req_i,
    input  wire turfio_pkg::wb_req_t ctl_req_i,
    output turfio_pkg::wb_rsp_t     dbg_rsp_o,
    output turfio_pkg::wb_rsp_t     ctl_rsp_o,
    output turfio_pkg::wbs_req_t    id_req_o,
    output turfio_pkg::wbs_req_t    sh_req_o,
    input  wire turfio_pkg::wb_rsp_t id_rsp_i,
    input  wire turfio_pkg::wb_rsp_t sh_rsp_i
);
    import turfio_pkg::*;

    // Select codes, 2 and 3 are unmapped
    localparam logic [1:0] SEL_ID = 2'd0;
    localparam logic [1:0] SEL_SH = 2'd1;

    arb_state_t                 state_q;
    // High when control master won last arbitration
    logic                       last_ctl_q;
    logic                       dbg_want;
    logic                       ctl_want;
    logic                       gnt_dbg;
    logic                       gnt_ctl;
    wb_req_t                    gnt_req;
    logic [1:0]                 gnt_sel;
    logic [1:0]                 sel_q;
    logic                       id_stb_q;
    logic                       sh_stb_q;
    logic                       err_q;
    logic                       fwd_we_q;
    logic [`TIO_SLV_ADR_W-1:0]  fwd_adr_q;
    logic [`TIO_DAT_W-1:0]      fwd_dat_q;
    wb_rsp_t                    slv_rsp;

    ////////////////////////////////////////////////////////////////////////
    // Arbitration
    ////////////////////////////////////////////////////////////////////////

    assign dbg_want = dbg_req_i.cyc & dbg_req_i.stb;
    assign ctl_want = ctl_req_i.cyc & ctl_req_i.stb;
    // Tie goes to whoever lost last time
    assign gnt_dbg  = dbg_want & (~ctl_want | last_ctl_q);
    assign gnt_ctl  = ctl_want & ~gnt_dbg;
    assign gnt_req  = gnt_dbg ? dbg_req_i : ctl_req_i;
    assign gnt_sel  = gnt_req.adr[`TIO_SEL_LSB +: 2];

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state_q    <= ARB_IDLE;
            // Debug master wins the first tie
            last_ctl_q <= 1'b1;
            sel_q      <= '0;
            id_stb_q   <= 1'b0;
            sh_stb_q   <= 1'b0;
            err_q      <= 1'b0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (gnt_dbg || gnt_ctl) begin
                        state_q    <= gnt_dbg ? ARB_DBG : ARB_CTL;
                        last_ctl_q <= gnt_ctl;
                        sel_q      <= gnt_sel;
                        id_stb_q   <= (gnt_sel == SEL_ID);
                        sh_stb_q   <= (gnt_sel == SEL_SH);
                    end
                end
                default: begin
                    // Done on the single-cycle ack or err
                    if (slv_rsp.ack || slv_rsp.err) begin
                        state_q  <= ARB_IDLE;
                        id_stb_q <= 1'b0;
                        sh_stb_q <= 1'b0;
                        err_q    <= 1'b0;
                    end else if (sel_q[1]) begin
                        // Unmapped, error one cycle after grant
                        err_q <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Request payload captured while idle, frozen during the grant
    always_ff @(posedge wb_clk_i) begin
        if (state_q == ARB_IDLE) begin
            fwd_we_q  <= gnt_req.we;
            fwd_adr_q <= gnt_req.adr[`TIO_SLV_ADR_W-1:0];
            fwd_dat_q <= gnt_req.dat;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Slave side
    ////////////////////////////////////////////////////////////////////////

    // Only one slave strobe at a time
    assign id_req_o = '{cyc: id_stb_q, stb: id_stb_q, we: fwd_we_q,
                        adr: fwd_adr_q, dat: fwd_dat_q};
    assign sh_req_o = '{cyc: sh_stb_q, stb: sh_stb_q, we: fwd_we_q,
                        adr: fwd_adr_q, dat: fwd_dat_q};

    // Response mux, unmapped window answers locally
    always_comb begin
        case (sel_q)
            SEL_ID:  slv_rsp = id_rsp_i;
            SEL_SH:  slv_rsp = sh_rsp_i;
            default: slv_rsp = '{ack: 1'b0, err: err_q, dat: '0};
        endcase
    end

    // Response to granted master only
    assign dbg_rsp_o = (state_q == ARB_DBG) ? slv_rsp : '0;
    assign ctl_rsp_o = (state_q == ARB_CTL) ? slv_rsp : '0;

endmodule

`default_nettype wire

// File: turfio_pkg.sv
`default_nettype none
`include "turfio_macros.svh"

package turfio_pkg;

    ////////////////////////////////////////////////////////////////////////
    // Bus structs
    ////////////////////////////////////////////////////////////////////////

    // Master request, full crate address
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [`TIO_ADR_W-1:0]   adr;
        logic [`TIO_DAT_W-1:0]   dat;
    } wb_req_t;

    // Slave request, address inside the slave window
    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [`TIO_SLV_ADR_W-1:0] adr;
        logic [`TIO_DAT_W-1:0]    dat;
    } wbs_req_t;

    // Response, same on both sides
    typedef struct packed {
        logic                  ack;
        logic                  err;
        logic [`TIO_DAT_W-1:0] dat;
    } wb_rsp_t;

    ////////////////////////////////////////////////////////////////////////
    // State and code enums
    ////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {ARB_IDLE, ARB_DBG, ARB_CTL} arb_state_t;

    typedef enum logic [1:0] {SH_IDLE, SH_LOW, SH_HIGH, SH_DONE} shift_state_t;

    // Code 3 is illegal, engine folds it onto SPI
    typedef enum logic [1:0] {
        TGT_JTAG = 2'd0,
        TGT_LMK  = 2'd1,
        TGT_SPI  = 2'd2
    } shift_target_t;

endpackage

`default_nettype wire

// File: turfio_macros.svh
`ifndef TURFIO_MACROS_SVH
`define TURFIO_MACROS_SVH

// Master side byte address, 4 MB window
`define TIO_ADR_W 22
// Each slave gets a 4 kB window
`define TIO_SLV_ADR_W 12
`define TIO_DAT_W 32
// Slave select field sits right above the slave window
`define TIO_SEL_LSB 12

// Device identifier, ASCII "TFIO"
`define TIO_IDENT 32'h5446_494F
// Version word fields
`define TIO_FW_DATE 16'h0000
`define TIO_VER_MAJOR 4'd0
`define TIO_VER_MINOR 4'd1
`define TIO_VER_REV 8'd2
`define TIO_VERSION {`TIO_FW_DATE, `TIO_VER_MAJOR, `TIO_VER_MINOR, `TIO_VER_REV}

// Cycles per serial clock half-period
`define TIO_SHIFT_DIV 4
// Shift control word: count in [4:0], target in [9:8]
`define TIO_SH_CNT_W 5
`define TIO_SH_TGT_LSB 8

// ID and control slave offsets
`define REG_IDENT 12'h000
`define REG_VERSION 12'h004
`define REG_SCRATCH 12'h008
`define REG_CONTROL 12'h00C
// Shift engine offsets
`define REG_SH_CTRL 12'h000
`define REG_SH_TX 12'h004
`define REG_SH_RX 12'h008
`define REG_SH_STAT 12'h00C

`endif
